// File: design/gnn_ctrl_pkg.sv
package gnn_ctrl_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int CMD_W           = 16;
    localparam int NUM_PE          = 4;
    localparam int MAX_REPLAY_ITER = 4;
    localparam int FIFO_DEPTH      = 8;
    localparam int STATION_DEPTH   = 4;
    localparam int NUM_FV_W        = 5;
    localparam int WB_W            = 4;

    localparam int ITER_W        = $clog2(MAX_REPLAY_ITER);
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
    localparam int STATION_PTR_W = $clog2(STATION_DEPTH);

    // Bank hold time and PE task time.
    localparam int BANK_BUSY_CYCLES = 4;
    localparam int PE_BASE_CYCLES   = 2;
    localparam int BUSY_CNT_W       = $clog2(BANK_BUSY_CYCLES + 1);
    localparam int PE_TIMER_W       = $clog2(PE_BASE_CYCLES + 4);

    // ----------------------------------------
    // Opcodes and decoder states
    // ----------------------------------------
    localparam logic [1:0] OP_TASK    = 2'b00;
    localparam logic [1:0] OP_REPLAY  = 2'b01;
    localparam logic [1:0] OP_NUM_FV  = 2'b10;
    localparam logic [1:0] OP_WEIGHTS = 2'b11;

    localparam logic [2:0] ST_IDLE          = 3'd0;
    localparam logic [2:0] ST_WAIT_GRANT    = 3'd1;
    localparam logic [2:0] ST_WAIT_REPLAY   = 3'd2;
    localparam logic [2:0] ST_WAIT_STREAM   = 3'd3;
    localparam logic [2:0] ST_WAIT_COMPLETE = 3'd4;

    // Same 16-bit word, read as a task or as a config update.
    typedef struct packed {
        logic [1:0] opcode;
        logic [3:0] iter_mask;
        logic [9:0] vertex_id;
    } task_view_t;

    typedef struct packed {
        logic [1:0] opcode;
        logic [8:0] reserved;
        logic [4:0] value;
    } config_view_t;

    typedef union packed {
        task_view_t   task_view;
        config_view_t config_view;
    } cmd_word_u;

endpackage

// File: design/command_fifo.sv
`timescale 1ns/1ps

module command_fifo (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cmd_valid,
    input  logic [gnn_ctrl_pkg::CMD_W-1:0] cmd_word,
    output logic                           cmd_ready,
    input  logic                           fifo_stall,
    output logic                           head_valid,
    output logic [gnn_ctrl_pkg::CMD_W-1:0] head_word
);

    logic [gnn_ctrl_pkg::CMD_W-1:0]      mem [gnn_ctrl_pkg::FIFO_DEPTH];
    logic [gnn_ctrl_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [gnn_ctrl_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [gnn_ctrl_pkg::FIFO_PTR_W:0]   count;
    logic                                push;
    logic                                pop;

    assign cmd_ready  = (count != gnn_ctrl_pkg::FIFO_DEPTH);
    assign head_valid = (count != '0);
    // Show-ahead read.
    assign head_word  = mem[rd_ptr];

    assign push = cmd_valid && cmd_ready;
    assign pop  = head_valid && !fifo_stall;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_word;
        end
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  head_valid,
    input  logic [gnn_ctrl_pkg::CMD_W-1:0]        head_word,
    input  logic                                  station_full,
    input  logic                                  station_empty,
    input  logic [gnn_ctrl_pkg::NUM_PE-1:0]       pe_idle,
    input  logic                                  grant,
    input  logic                                  bank_busy,
    input  logic                                  stream_end,
    input  logic                                  vertex_done,
    output logic                                  fifo_stall,
    output logic                                  task_valid,
    output logic [gnn_ctrl_pkg::CMD_W-1:0]        task_word,
    output logic                                  req,
    output logic                                  mem_valid,
    output logic [gnn_ctrl_pkg::CMD_W-1:0]        mem_word,
    output logic [gnn_ctrl_pkg::ITER_W-1:0]       replay_iter,
    output logic [gnn_ctrl_pkg::NUM_FV_W-1:0]     num_fv,
    output logic [gnn_ctrl_pkg::WB_W-1:0]         weights_boundary,
    output logic                                  cntl_done,
    output logic                                  task_complete
);

    gnn_ctrl_pkg::cmd_word_u                 cmd;
    logic [2:0]                              state;
    logic [2:0]                              next_state;
    logic [gnn_ctrl_pkg::CMD_W-1:0]          held_word;
    logic [gnn_ctrl_pkg::CMD_W-1:0]          next_held;
    logic [gnn_ctrl_pkg::ITER_W-1:0]         next_iter;
    logic [gnn_ctrl_pkg::NUM_FV_W-1:0]       next_num_fv;
    logic [gnn_ctrl_pkg::WB_W-1:0]           next_wb;
    logic                                    engine_drained;

    assign cmd            = head_word;
    assign task_word      = head_word;
    assign mem_word       = held_word;
    assign engine_drained = station_empty && (&pe_idle) && !bank_busy;

    // ----------------------------------------
    // Dispatch and wait states
    // ----------------------------------------
    always_comb begin
        next_state    = state;
        next_held     = held_word;
        next_iter     = replay_iter;
        next_num_fv   = num_fv;
        next_wb       = weights_boundary;
        fifo_stall    = 1'b1;
        task_valid    = 1'b0;
        req           = 1'b0;
        mem_valid     = 1'b0;
        cntl_done     = 1'b0;
        task_complete = 1'b0;

        case (state)
            gnn_ctrl_pkg::ST_IDLE: begin
                // Every word leaves the FIFO in the cycle it is dispatched.
                fifo_stall = station_full;
                if (head_valid && !station_full) begin
                    case (cmd.task_view.opcode)
                        gnn_ctrl_pkg::OP_TASK: begin
                            if (cmd.task_view.iter_mask[replay_iter]) begin
                                task_valid = 1'b1;
                            end else begin
                                req        = 1'b1;
                                next_held  = head_word;
                                next_state = gnn_ctrl_pkg::ST_WAIT_GRANT;
                            end
                        end
                        gnn_ctrl_pkg::OP_REPLAY: begin
                            next_held  = head_word;
                            next_state = gnn_ctrl_pkg::ST_WAIT_REPLAY;
                        end
                        gnn_ctrl_pkg::OP_NUM_FV: begin
                            next_num_fv = cmd.config_view.value;
                        end
                        default: begin
                            next_wb    = cmd.config_view.value[gnn_ctrl_pkg::WB_W-1:0];
                            next_state = gnn_ctrl_pkg::ST_WAIT_STREAM;
                        end
                    endcase
                end
            end

            gnn_ctrl_pkg::ST_WAIT_GRANT: begin
                if (grant) begin
                    mem_valid  = 1'b1;
                    next_state = gnn_ctrl_pkg::ST_IDLE;
                end else begin
                    req = 1'b1;
                end
            end

            gnn_ctrl_pkg::ST_WAIT_REPLAY: begin
                if (engine_drained) begin
                    if (replay_iter == gnn_ctrl_pkg::ITER_W'(gnn_ctrl_pkg::MAX_REPLAY_ITER - 1)) begin
                        cntl_done  = 1'b1;
                        next_state = gnn_ctrl_pkg::ST_WAIT_COMPLETE;
                    end else begin
                        // Replay the stream once more.
                        mem_valid  = 1'b1;
                        next_iter  = replay_iter + 1'b1;
                        next_state = gnn_ctrl_pkg::ST_WAIT_STREAM;
                    end
                end
            end

            gnn_ctrl_pkg::ST_WAIT_STREAM: begin
                if (stream_end) begin
                    next_state = gnn_ctrl_pkg::ST_IDLE;
                end
            end

            gnn_ctrl_pkg::ST_WAIT_COMPLETE: begin
                if (vertex_done) begin
                    task_complete = 1'b1;
                    // Next job starts again at iteration zero.
                    next_iter     = '0;
                    next_state    = gnn_ctrl_pkg::ST_IDLE;
                end
            end

            default: begin
                next_state = gnn_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // State registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= gnn_ctrl_pkg::ST_IDLE;
            replay_iter      <= '0;
            num_fv           <= '0;
            weights_boundary <= '0;
        end else begin
            state            <= next_state;
            replay_iter      <= next_iter;
            num_fv           <= next_num_fv;
            weights_boundary <= next_wb;
        end
    end

    // Load or replay word held for the memory port.
    always_ff @(posedge clk) begin
        held_word <= next_held;
    end

endmodule

// File: design/task_station.sv
`timescale 1ns/1ps

module task_station (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            task_valid,
    input  logic [gnn_ctrl_pkg::CMD_W-1:0]  task_word,
    output logic                            station_full,
    output logic                            station_empty,
    input  logic [gnn_ctrl_pkg::NUM_PE-1:0] pe_idle,
    output logic [gnn_ctrl_pkg::NUM_PE-1:0] pe_start,
    output logic [gnn_ctrl_pkg::CMD_W-1:0]  pe_task
);

    logic [gnn_ctrl_pkg::CMD_W-1:0]         entry [gnn_ctrl_pkg::STATION_DEPTH];
    logic [gnn_ctrl_pkg::STATION_PTR_W-1:0] head_ptr;
    logic [gnn_ctrl_pkg::STATION_PTR_W-1:0] tail_ptr;
    logic [gnn_ctrl_pkg::STATION_PTR_W:0]   count;
    logic [gnn_ctrl_pkg::NUM_PE-1:0]        lowest_idle;
    logic                                   issue;

    assign station_full  = (count == gnn_ctrl_pkg::STATION_DEPTH);
    assign station_empty = (count == '0);

    // Isolate the lowest set bit of the idle mask.
    assign lowest_idle = pe_idle & (~pe_idle + 1'b1);
    assign issue       = !station_empty && (pe_idle != '0);
    assign pe_start    = issue ? lowest_idle : '0;
    assign pe_task     = entry[head_ptr];

    always_ff @(posedge clk) begin
        if (task_valid) begin
            entry[tail_ptr] <= task_word;
        end
    end

    // ----------------------------------------
    // Queue control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (task_valid) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (issue) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({task_valid, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/pe_array.sv
`timescale 1ns/1ps

module pe_array (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [gnn_ctrl_pkg::NUM_PE-1:0] pe_start,
    input  logic [gnn_ctrl_pkg::CMD_W-1:0]  pe_task,
    output logic [gnn_ctrl_pkg::NUM_PE-1:0] pe_idle
);

    logic [gnn_ctrl_pkg::PE_TIMER_W-1:0] timer [gnn_ctrl_pkg::NUM_PE];

    // Task time grows with the low bits of the vertex id.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < gnn_ctrl_pkg::NUM_PE; i++) begin
                timer[i] <= '0;
            end
        end else begin
            for (int i = 0; i < gnn_ctrl_pkg::NUM_PE; i++) begin
                if (pe_start[i]) begin
                    timer[i] <= gnn_ctrl_pkg::PE_TIMER_W'(gnn_ctrl_pkg::PE_BASE_CYCLES)
                              + gnn_ctrl_pkg::PE_TIMER_W'(pe_task[1:0]);
                end else if (timer[i] != '0) begin
                    timer[i] <= timer[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < gnn_ctrl_pkg::NUM_PE; i++) begin
            pe_idle[i] = (timer[i] == '0);
        end
    end

endmodule

// File: design/mem_bank_port.sv
`timescale 1ns/1ps

module mem_bank_port (
    input  logic clk,
    input  logic reset,
    input  logic req,
    output logic grant,
    input  logic mem_valid,
    output logic bank_busy
);

    logic [gnn_ctrl_pkg::BUSY_CNT_W-1:0] busy_cnt;

    assign bank_busy = (busy_cnt != '0);

    // ----------------------------------------
    // Grant
    // ----------------------------------------
    // One-cycle grant, never back to back, only on a free bank.
    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= 1'b0;
        end else begin
            grant <= req && !grant && !bank_busy;
        end
    end

    // ----------------------------------------
    // Busy window
    // ----------------------------------------
    // Loads and replay packets both occupy the bank.
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (mem_valid) begin
            busy_cnt <= gnn_ctrl_pkg::BUSY_CNT_W'(gnn_ctrl_pkg::BANK_BUSY_CYCLES);
        end else if (bank_busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

endmodule

// File: design/gnn_ctrl_top.sv
`timescale 1ns/1ps

module gnn_ctrl_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cmd_valid,
    input  logic [gnn_ctrl_pkg::CMD_W-1:0]        cmd_word,
    output logic                                  cmd_ready,
    input  logic                                  stream_end,
    input  logic                                  vertex_done,
    output logic                                  issue_valid,
    output logic [gnn_ctrl_pkg::CMD_W-1:0]        issue_word,
    output logic                                  mem_valid,
    output logic [gnn_ctrl_pkg::CMD_W-1:0]        mem_word,
    output logic [gnn_ctrl_pkg::ITER_W-1:0]       replay_iter,
    output logic [gnn_ctrl_pkg::NUM_FV_W-1:0]     num_fv,
    output logic [gnn_ctrl_pkg::WB_W-1:0]         weights_boundary,
    output logic                                  cntl_done,
    output logic                                  task_complete
);

    logic                            head_valid;
    logic [gnn_ctrl_pkg::CMD_W-1:0]  head_word;
    logic                            fifo_stall;
    logic                            task_valid;
    logic [gnn_ctrl_pkg::CMD_W-1:0]  task_word;
    logic                            station_full;
    logic                            station_empty;
    logic [gnn_ctrl_pkg::NUM_PE-1:0] pe_idle;
    logic [gnn_ctrl_pkg::NUM_PE-1:0] pe_start;
    logic [gnn_ctrl_pkg::CMD_W-1:0]  pe_task;
    logic                            req;
    logic                            grant;
    logic                            bank_busy;

    // Any PE start is an issue.
    assign issue_valid = |pe_start;
    assign issue_word  = pe_task;

    command_fifo fifo_i (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .cmd_ready  (cmd_ready),
        .fifo_stall (fifo_stall),
        .head_valid (head_valid),
        .head_word  (head_word)
    );

    command_decoder decoder_i (
        .clk              (clk),
        .reset            (reset),
        .head_valid       (head_valid),
        .head_word        (head_word),
        .station_full     (station_full),
        .station_empty    (station_empty),
        .pe_idle          (pe_idle),
        .grant            (grant),
        .bank_busy        (bank_busy),
        .stream_end       (stream_end),
        .vertex_done      (vertex_done),
        .fifo_stall       (fifo_stall),
        .task_valid       (task_valid),
        .task_word        (task_word),
        .req              (req),
        .mem_valid        (mem_valid),
        .mem_word         (mem_word),
        .replay_iter      (replay_iter),
        .num_fv           (num_fv),
        .weights_boundary (weights_boundary),
        .cntl_done        (cntl_done),
        .task_complete    (task_complete)
    );

    task_station station_i (
        .clk           (clk),
        .reset         (reset),
        .task_valid    (task_valid),
        .task_word     (task_word),
        .station_full  (station_full),
        .station_empty (station_empty),
        .pe_idle       (pe_idle),
        .pe_start      (pe_start),
        .pe_task       (pe_task)
    );

    pe_array pe_i (
        .clk      (clk),
        .reset    (reset),
        .pe_start (pe_start),
        .pe_task  (pe_task),
        .pe_idle  (pe_idle)
    );

    mem_bank_port bank_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .grant     (grant),
        .mem_valid (mem_valid),
        .bank_busy (bank_busy)
    );

endmodule

// File: verif/gnn_ctrl_asserts.sv
`timescale 1ns/1ps

module gnn_ctrl_asserts (
    input logic clk,
    input logic reset,
    input logic req,
    input logic grant,
    input logic mem_valid,
    input logic task_valid,
    input logic cntl_done,
    input logic task_complete
);

    // A load request stays up until the bank answers.
    req_holds: assert property (@(posedge clk) disable iff (reset)
        req |=> (req || grant))
        else $error("req dropped before grant");

    one_target: assert property (@(posedge clk) disable iff (reset)
        !(mem_valid && task_valid))
        else $error("mem_valid and task_valid in the same cycle");

    // The engine is quiet between the done pulses.
    quiet_after_done: assert property (@(posedge clk) disable iff (reset)
        cntl_done |=> (!mem_valid until task_complete))
        else $error("mem_valid between cntl_done and task_complete");

endmodule

bind command_decoder gnn_ctrl_asserts asserts_i (
    .clk           (clk),
    .reset         (reset),
    .req           (req),
    .grant         (grant),
    .mem_valid     (mem_valid),
    .task_valid    (task_valid),
    .cntl_done     (cntl_done),
    .task_complete (task_complete)
);

// File: verif/gnn_ctrl_tb.sv
`timescale 1ns/1ps

module gnn_ctrl_tb;

    localparam int NUM_JOBS    = 6;
    localparam int CYCLE_LIMIT = 400 * NUM_JOBS;

    logic                                  clk;
    logic                                  reset;
    logic                                  cmd_valid;
    logic [gnn_ctrl_pkg::CMD_W-1:0]        cmd_word;
    logic                                  cmd_ready;
    logic                                  stream_end;
    logic                                  vertex_done;
    logic                                  issue_valid;
    logic [gnn_ctrl_pkg::CMD_W-1:0]        issue_word;
    logic                                  mem_valid;
    logic [gnn_ctrl_pkg::CMD_W-1:0]        mem_word;
    logic [gnn_ctrl_pkg::ITER_W-1:0]       replay_iter;
    logic [gnn_ctrl_pkg::NUM_FV_W-1:0]     num_fv;
    logic [gnn_ctrl_pkg::WB_W-1:0]         weights_boundary;
    logic                                  cntl_done;
    logic                                  task_complete;

    // Reference model state.
    logic [15:0] stim [$];
    logic [15:0] held [$];
    logic [15:0] exp_issue [$];
    logic [15:0] exp_mem [$];
    int          model_iter;
    int          shown_iter;
    int          exp_fv;
    int          exp_wb;
    int          sent_count;
    int          jobs_done;
    int          cycles = 0;
    int          stream_delay;
    int          vertex_delay;
    bit          hold_pops;
    bit          exp_done;
    bit          wait_complete;
    bit          stream_req;
    bit          vertex_req;

    gnn_ctrl_top dut_i (
        .clk              (clk),
        .reset            (reset),
        .cmd_valid        (cmd_valid),
        .cmd_word         (cmd_word),
        .cmd_ready        (cmd_ready),
        .stream_end       (stream_end),
        .vertex_done      (vertex_done),
        .issue_valid      (issue_valid),
        .issue_word       (issue_word),
        .mem_valid        (mem_valid),
        .mem_word         (mem_word),
        .replay_iter      (replay_iter),
        .num_fv           (num_fv),
        .weights_boundary (weights_boundary),
        .cntl_done        (cntl_done),
        .task_complete    (task_complete)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s, got 0x%0h, expected 0x%0h",
                                $time, what, actual, expected));
        end
    endtask

    // Each job has four segments, each closed by a replay mark.
    task automatic build_jobs();
        int n;
        int r;
        for (int j = 0; j < NUM_JOBS; j++) begin
            for (int s = 0; s < gnn_ctrl_pkg::MAX_REPLAY_ITER; s++) begin
                n = 2 + ($urandom % 5);
                for (int k = 0; k < n; k++) begin
                    r = $urandom % 10;
                    if (r < 7) begin
                        stim.push_back({gnn_ctrl_pkg::OP_TASK, 14'($urandom)});
                    end else if (r < 9) begin
                        stim.push_back({gnn_ctrl_pkg::OP_NUM_FV, 14'($urandom)});
                    end else begin
                        stim.push_back({gnn_ctrl_pkg::OP_WEIGHTS, 14'($urandom)});
                    end
                end
                stim.push_back({gnn_ctrl_pkg::OP_REPLAY, 14'($urandom)});
            end
        end
    endtask

    // ----------------------------------------
    // Model of one popped command
    // ----------------------------------------
    task automatic route_word(input logic [15:0] w);
        case (w[15:14])
            gnn_ctrl_pkg::OP_TASK: begin
                // Mask bits sit at 13:10, one per replay iteration.
                if (w[10 + model_iter]) begin
                    exp_issue.push_back(w);
                end else begin
                    exp_mem.push_back(w);
                end
            end
            gnn_ctrl_pkg::OP_REPLAY: begin
                hold_pops = 1'b1;
                if (model_iter < gnn_ctrl_pkg::MAX_REPLAY_ITER - 1) begin
                    exp_mem.push_back(w);
                    model_iter++;
                end else begin
                    exp_done = 1'b1;
                end
            end
            gnn_ctrl_pkg::OP_NUM_FV: begin
                exp_fv = w[4:0];
            end
            default: begin
                exp_wb     = w[3:0];
                hold_pops  = 1'b1;
                stream_req = 1'b1;
            end
        endcase
    endtask

    task automatic observe_cycle();
        logic [15:0] w;
        check_value(num_fv, exp_fv, "num_fv");
        check_value(weights_boundary, exp_wb, "weights_boundary");
        check_value(replay_iter, shown_iter, "replay_iter");
        check_value(cmd_ready, held.size() < gnn_ctrl_pkg::FIFO_DEPTH, "cmd_ready vs occupancy");
        if (issue_valid) begin
            check_value(exp_issue.size() != 0, 1, "issue with no task expected");
            w = exp_issue.pop_front();
            check_value(issue_word, w, "issue_word");
        end
        if (mem_valid) begin
            check_value(exp_mem.size() != 0, 1, "mem_valid with no word expected");
            w = exp_mem.pop_front();
            check_value(mem_word, w, "mem_word");
            if (w[15:14] == gnn_ctrl_pkg::OP_REPLAY) begin
                shown_iter++;
                stream_req = 1'b1;
            end
        end
        if (cntl_done) begin
            check_value(exp_done, 1, "cntl_done without a final replay mark");
            check_value(exp_issue.size() + exp_mem.size(), 0, "work left at cntl_done");
            exp_done      = 1'b0;
            wait_complete = 1'b1;
            vertex_req    = 1'b1;
        end
        if (dut_i.head_valid && !dut_i.fifo_stall) begin
            check_value(hold_pops, 0, "command popped while the decoder waits");
            check_value(held.size() != 0, 1, "pop from an empty FIFO");
            w = held.pop_front();
            check_value(dut_i.head_word, w, "FIFO head word");
            route_word(w);
        end
        if (cmd_valid && cmd_ready) begin
            held.push_back(cmd_word);
            sent_count++;
        end
        if (stream_end) begin
            hold_pops = 1'b0;
        end
        if (task_complete) begin
            check_value(wait_complete, 1, "task_complete without cntl_done");
            check_value(vertex_done, 1, "task_complete apart from vertex_done");
            wait_complete = 1'b0;
            hold_pops     = 1'b0;
            model_iter    = 0;
            shown_iter    = 0;
            jobs_done++;
        end
    endtask

    always @(negedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abort_run("Timeout: the jobs did not finish within the cycle limit");
        end
        #1;
        if (!reset) begin
            observe_cycle();
        end
    end

    // ----------------------------------------
    // Host and event stimulus
    // ----------------------------------------
    task automatic drive_inputs();
        cmd_valid   = 1'b0;
        stream_end  = 1'b0;
        vertex_done = 1'b0;
        if (sent_count < stim.size() && ($urandom % 4) != 0) begin
            cmd_valid = 1'b1;
            cmd_word  = stim[sent_count];
        end
        if (stream_req) begin
            if (stream_delay < 0) begin
                stream_delay = $urandom % 4;
            end
            if (stream_delay == 0) begin
                stream_end   = 1'b1;
                stream_req   = 1'b0;
                stream_delay = -1;
            end else begin
                stream_delay--;
            end
        end
        if (vertex_req) begin
            if (vertex_delay < 0) begin
                vertex_delay = $urandom % 4;
            end
            if (vertex_delay == 0) begin
                vertex_done  = 1'b1;
                vertex_req   = 1'b0;
                vertex_delay = -1;
            end else begin
                vertex_delay--;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h1964_87af));
        reset         = 1'b1;
        cmd_valid     = 1'b0;
        cmd_word      = '0;
        stream_end    = 1'b0;
        vertex_done   = 1'b0;
        model_iter    = 0;
        shown_iter    = 0;
        exp_fv        = 0;
        exp_wb        = 0;
        sent_count    = 0;
        jobs_done     = 0;
        stream_delay  = -1;
        vertex_delay  = -1;
        hold_pops     = 1'b0;
        exp_done      = 1'b0;
        wait_complete = 1'b0;
        stream_req    = 1'b0;
        vertex_req    = 1'b0;
        build_jobs();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (jobs_done < NUM_JOBS) begin
            @(negedge clk);
            drive_inputs();
        end
        check_value(sent_count, stim.size(), "words accepted");
        check_value(held.size(), 0, "words left in the FIFO");
        check_value(exp_issue.size() + exp_mem.size(), 0, "expected outputs never seen");
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: filelist.f
design/gnn_ctrl_pkg.sv
design/command_fifo.sv
design/command_decoder.sv
design/task_station.sv
design/pe_array.sv
design/mem_bank_port.sv
design/gnn_ctrl_top.sv
verif/gnn_ctrl_asserts.sv
verif/gnn_ctrl_tb.sv

// File: Bender.yml
package:
  name: gnn_ctrl

sources:
  - design/gnn_ctrl_pkg.sv
  - design/command_fifo.sv
  - design/command_decoder.sv
  - design/task_station.sv
  - design/pe_array.sv
  - design/mem_bank_port.sv
  - design/gnn_ctrl_top.sv
  - target: test
    files:
      - verif/gnn_ctrl_asserts.sv
      - verif/gnn_ctrl_tb.sv
